/* verilog/rv32_isa_pkg.sv */
// ==============================
// rv32 isa package: opcode, funct3 and CSR address constants
// and the decoded instruction word
// ==============================
`default_nettype none

package rv32_isa_pkg;

  // opcode shared by all Zicsr instructions
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // operation in funct3[1:0], funct3[2] picks the zimm source
  localparam logic [1:0] CSR_RW = 2'b01;
  localparam logic [1:0] CSR_RS = 2'b10;
  localparam logic [1:0] CSR_RC = 2'b11;

  // machine counters and scratch
  localparam logic [11:0] MSCRATCH  = 12'h340;
  localparam logic [11:0] MCYCLE    = 12'hB00;
  localparam logic [11:0] MINSTRET  = 12'hB02;
  localparam logic [11:0] MCYCLEH   = 12'hB80;
  localparam logic [11:0] MINSTRETH = 12'hB82;

  // generic I-type layout
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ir_i_t;

  // same bits seen as a CSR instruction
  typedef struct packed {
    logic [11:0] csr_addr;
    logic [4:0]  src;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ir_csr_t;

  typedef union packed {
    ir_i_t   i_type;
    ir_csr_t csr;
  } ir_u;

endpackage

`default_nettype wire

/* verilog/ex_pipe_pkg.sv */
// ==============================
// execute pipe package: structs between decode, CSR stages and write-back
// ==============================
`default_nettype none

package ex_pipe_pkg;

  // item handed over by decode
  typedef struct packed {
    rv32_isa_pkg::ir_u ir;
    logic [31:0]       op1;
    logic              csr;
  } decode_t;

  // resolved CSR request out of stage one
  typedef struct packed {
    logic [11:0] addr;
    logic [1:0]  op;
    logic [31:0] wdata;
    logic [4:0]  rd;
    logic        rd_en;
    logic        wr_en;
    logic        csr;
  } csr_req_t;

  // register file write-back, single-cycle pulse
  typedef struct packed {
    logic        en;
    logic [4:0]  sel;
    logic [31:0] data;
  } regwr_t;

endpackage

`default_nettype wire

/* verilog/csr_counter.sv */
// ==============================
// csr counter: free running counter with 32-bit half writes
// ==============================
`default_nettype none
`timescale 1ns/1ps

module csr_counter #(
  parameter int WIDTH = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        inc,
  input  logic        wr_lo,
  input  logic        wr_hi,
  input  logic [31:0] wdata,
  output logic [63:0] count
);

  logic [WIDTH-1:0] cnt;
  logic [63:0]      wr_val;

  // merge the written half into the current value
  always_comb begin
    wr_val = 64'(cnt);
    if (wr_lo) begin
      wr_val[31:0] = wdata;
    end
    if (wr_hi) begin
      wr_val[63:32] = wdata;
    end
  end

  // a write takes the place of the increment
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (wr_lo || wr_hi) begin
      cnt <= wr_val[WIDTH-1:0];
    end else if (inc) begin
      cnt <= cnt + 1'b1;
    end
  end

  // bits above WIDTH read as zero
  assign count = 64'(cnt);

endmodule

`default_nettype wire

/* verilog/csr_operand_stage.sv */
// ==============================
// csr operand stage: picks the CSR operand and derives read/write enables
// ==============================
`default_nettype none
`timescale 1ns/1ps

module csr_operand_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_pipe_pkg::decode_t  decode,
  input  logic                  decode_vld,
  output logic                  decode_rdy,
  output ex_pipe_pkg::csr_req_t req,
  output logic                  req_vld,
  input  logic                  req_rdy
);

  logic                  is_csr;
  logic [1:0]            op;
  logic                  src_nz;
  ex_pipe_pkg::csr_req_t next_req;

  // empty, or the held item leaves this cycle
  assign decode_rdy = ~req_vld | req_rdy;

  always_comb begin
    is_csr = decode.csr && (decode.ir.csr.opcode == rv32_isa_pkg::OP_SYSTEM);
    op     = decode.ir.csr.funct3[1:0];
    src_nz = (decode.ir.csr.src != 5'd0);

    next_req.addr = decode.ir.csr.csr_addr;
    next_req.op   = op;
    next_req.rd   = decode.ir.csr.rd;
    next_req.csr  = is_csr;

    // funct3[2] selects zero-extended zimm over rs1
    if (decode.ir.csr.funct3[2]) begin
      next_req.wdata = {27'd0, decode.ir.csr.src};
    end else begin
      next_req.wdata = decode.op1;
    end

    next_req.rd_en = is_csr && (decode.ir.csr.rd != 5'd0);
    // set/clear with a zero source never writes
    next_req.wr_en = is_csr && ((op == rv32_isa_pkg::CSR_RW) ||
                                (((op == rv32_isa_pkg::CSR_RS) ||
                                  (op == rv32_isa_pkg::CSR_RC)) && src_nz));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_vld <= 1'b0;
    end else if (decode_rdy) begin
      req_vld <= decode_vld;
    end
  end

  // payload only moves on an accepted item
  always_ff @(posedge clk) begin
    if (decode_rdy && decode_vld) begin
      req <= next_req;
    end
  end

endmodule

`default_nettype wire

/* verilog/csr_access_stage.sv */
// ==============================
// csr access stage: CSR read-modify-write, counters and write-back
// ==============================
`default_nettype none
`timescale 1ns/1ps

module csr_access_stage #(
  parameter int CNT_WIDTH = 64
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_pipe_pkg::csr_req_t req,
  input  logic                  req_vld,
  output ex_pipe_pkg::regwr_t   regwr,
  output logic                  req_rdy
);

  // phase 0 reads, phase 1 is the inserted write cycle
  logic        phase;
  logic        rd_cycle;
  logic        start_wr;
  logic        retire;
  logic [11:0] wr_addr;
  logic [31:0] wr_data;
  logic [31:0] mscratch;
  logic [31:0] old_val;
  logic [31:0] new_val;
  logic [63:0] cycle_val;
  logic [63:0] instret_val;
  logic        cyc_wr_lo;
  logic        cyc_wr_hi;
  logic        ret_wr_lo;
  logic        ret_wr_hi;

  assign req_rdy  = ~phase;
  assign rd_cycle = req_vld & ~phase;
  assign start_wr = rd_cycle & req.wr_en;
  // a writing item retires at the end of its write cycle
  assign retire   = (rd_cycle & ~req.wr_en) | phase;

  // ==============================
  // read and modify
  // ==============================
  always_comb begin
    old_val = 32'd0;
    if (req.csr) begin
      case (req.addr)
        rv32_isa_pkg::MCYCLE:    old_val = cycle_val[31:0];
        rv32_isa_pkg::MCYCLEH:   old_val = cycle_val[63:32];
        rv32_isa_pkg::MINSTRET:  old_val = instret_val[31:0];
        rv32_isa_pkg::MINSTRETH: old_val = instret_val[63:32];
        rv32_isa_pkg::MSCRATCH:  old_val = mscratch;
        default:                 old_val = 32'd0;
      endcase
    end
  end

  always_comb begin
    case (req.op)
      rv32_isa_pkg::CSR_RW: new_val = req.wdata;
      rv32_isa_pkg::CSR_RS: new_val = old_val | req.wdata;
      rv32_isa_pkg::CSR_RC: new_val = old_val & ~req.wdata;
      default:              new_val = old_val;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else begin
      phase <= start_wr;
    end
  end

  // write target held for the write cycle
  always_ff @(posedge clk) begin
    if (start_wr) begin
      wr_addr <= req.addr;
      wr_data <= new_val;
    end
  end

  // ==============================
  // storage, written at the end of phase 1
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mscratch <= 32'd0;
    end else if (phase && (wr_addr == rv32_isa_pkg::MSCRATCH)) begin
      mscratch <= wr_data;
    end
  end

  assign cyc_wr_lo = phase && (wr_addr == rv32_isa_pkg::MCYCLE);
  assign cyc_wr_hi = phase && (wr_addr == rv32_isa_pkg::MCYCLEH);
  assign ret_wr_lo = phase && (wr_addr == rv32_isa_pkg::MINSTRET);
  assign ret_wr_hi = phase && (wr_addr == rv32_isa_pkg::MINSTRETH);

  // a follower read in the next cycle already sees the written value
  csr_counter #(.WIDTH(CNT_WIDTH)) cycle_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .inc   (1'b1),
    .wr_lo (cyc_wr_lo),
    .wr_hi (cyc_wr_hi),
    .wdata (wr_data),
    .count (cycle_val)
  );

  csr_counter #(.WIDTH(CNT_WIDTH)) instret_cnt (
    .clk   (clk),
    .rst_n (rst_n),
    .inc   (retire),
    .wr_lo (ret_wr_lo),
    .wr_hi (ret_wr_hi),
    .wdata (wr_data),
    .count (instret_val)
  );

  // write-back pulse carries the old CSR value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regwr <= '0;
    end else begin
      regwr.en <= rd_cycle & req.rd_en;
      if (rd_cycle) begin
        regwr.sel  <= req.rd;
        regwr.data <= old_val;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/ex_csr_top.sv */
// ==============================
// ex csr top: two-stage CSR execute path
// ==============================
`default_nettype none
`timescale 1ns/1ps

module ex_csr_top #(
  parameter int CNT_WIDTH = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ex_pipe_pkg::decode_t decode,
  input  logic                 decode_vld,
  output logic                 decode_rdy,
  output ex_pipe_pkg::regwr_t  regwr
);

  // stage one to stage two
  ex_pipe_pkg::csr_req_t req;
  logic                  req_vld;
  logic                  req_rdy;

  csr_operand_stage u_operand (
    .clk        (clk),
    .rst_n      (rst_n),
    .decode     (decode),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy),
    .req        (req),
    .req_vld    (req_vld),
    .req_rdy    (req_rdy)
  );

  csr_access_stage #(.CNT_WIDTH(CNT_WIDTH)) u_access (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .req_vld (req_vld),
    .regwr   (regwr),
    .req_rdy (req_rdy)
  );

endmodule

`default_nettype wire

/* dv/ex_csr_assert.sv */
// ==============================
// handshake and write-back rules of the CSR access stage
// ==============================
`default_nettype none
`timescale 1ns/1ps

module ex_csr_assert (
  input logic                clk,
  input logic                rst_n,
  input logic                req_rdy,
  input logic                phase,
  input ex_pipe_pkg::regwr_t regwr
);

  // x0 is never a write-back target
  a_wb_sel: assert property (@(posedge clk) disable iff (!rst_n)
    regwr.en |-> (regwr.sel != 5'd0))
    else $error("regwr.en high with sel zero");

  // the inserted write cycle is a single cycle
  a_stall_one: assert property (@(posedge clk) disable iff (!rst_n)
    !req_rdy |=> req_rdy)
    else $error("req_rdy low for more than one cycle");

  // phase high alongside the pulse marks an item that wrote
  a_wb_after_write: assert property (@(posedge clk) disable iff (!rst_n)
    (regwr.en && phase) |=> !regwr.en)
    else $error("regwr.en held high after a writing item");

endmodule

bind csr_access_stage ex_csr_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .req_rdy (req_rdy),
  .phase   (phase),
  .regwr   (regwr)
);

`default_nettype wire

/* dv/tb_ex_csr.sv */
// ==============================
// testbench for the two-stage CSR execute path
// ==============================
`default_nettype none
`timescale 1ns/1ps

module tb_ex_csr;

  localparam int TIMEOUT = 50;

  logic                 clk;
  logic                 rst_n;
  ex_pipe_pkg::decode_t decode;
  logic                 decode_vld;
  logic                 decode_rdy;
  ex_pipe_pkg::regwr_t  regwr;

  ex_pipe_pkg::regwr_t  wb_q[$];
  int                   stall_cnt;
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  integer               seed;
  logic [31:0]          scratch_model;

  ex_csr_top #(.CNT_WIDTH(64)) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .decode     (decode),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy),
    .regwr      (regwr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // write-back pulses and stall cycles sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && regwr.en) begin
      wb_q.push_back(regwr);
    end
    if (rst_n && !decode_rdy) begin
      stall_cnt++;
    end
  end

  // ==============================
  // encoders and reference model
  // ==============================
  function automatic ex_pipe_pkg::decode_t encode_csr(input logic [2:0] f3,
      input logic [11:0] addr, input logic [4:0] src, input logic [4:0] rd,
      input logic [31:0] op1);
    ex_pipe_pkg::decode_t item;
    item.ir.i_type.imm12  = addr;
    item.ir.i_type.rs1    = src;
    item.ir.i_type.funct3 = f3;
    item.ir.i_type.rd     = rd;
    item.ir.i_type.opcode = rv32_isa_pkg::OP_SYSTEM;
    item.op1              = op1;
    item.csr              = 1'b1;
    return item;
  endfunction

  function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] old,
      input logic [31:0] operand);
    case (op)
      rv32_isa_pkg::CSR_RW: return operand;
      rv32_isa_pkg::CSR_RS: return old | operand;
      default:              return old & ~operand;
    endcase
  endfunction

  // ==============================
  // driver and capture
  // ==============================
  task automatic issue(input ex_pipe_pkg::decode_t item);
    int waited;
    waited     = 0;
    decode     = item;
    decode_vld = 1'b1;
    while (!decode_rdy && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!decode_rdy) begin
      $display("decode_rdy stayed low for %0d cycles, item dropped", TIMEOUT);
      errors++;
    end else begin
      @(posedge clk);
      #2;
    end
    decode_vld = 1'b0;
  endtask

  task automatic take_wb(output ex_pipe_pkg::regwr_t wb);
    int waited;
    waited = 0;
    while (wb_q.size() == 0 && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (wb_q.size() == 0) begin
      $display("no write-back pulse within %0d cycles", TIMEOUT);
      errors++;
      wb = '0;
    end else begin
      wb = wb_q.pop_front();
    end
  endtask

  // csrrs x1, addr, x0
  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    ex_pipe_pkg::regwr_t wb;
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RS}, addr, 5'd0, 5'd1, 32'd0));
    take_wb(wb);
    data = wb.data;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic drain();
    idle(3);
    wb_q.delete();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
      input logic [31:0] act);
    $display("Fail %s: expected %h, actual %h", name, exp, act);
    errors++;
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: %0d error(s)", name, errors - err_start);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic mscratch_all_ops();
    int                  err_start;
    int                  i;
    logic                imm;
    logic [1:0]          op;
    logic [4:0]          src;
    logic [31:0]         rnd;
    logic [31:0]         operand;
    logic [31:0]         old;
    logic [31:0]         rd_val;
    ex_pipe_pkg::regwr_t wb;
    err_start = errors;
    drain();
    for (i = 0; i < 6; i++) begin
      imm = (i >= 3);
      op  = 2'(i % 3 + 1);
      rnd = $random(seed);
      // zimm form takes only the low five bits
      src     = imm ? rnd[4:0] : 5'd6;
      operand = imm ? {27'd0, rnd[4:0]} : rnd;
      old     = scratch_model;
      if (op == rv32_isa_pkg::CSR_RW || src != 5'd0) begin
        scratch_model = apply_op(op, old, operand);
      end
      issue(encode_csr({imm, op}, rv32_isa_pkg::MSCRATCH, src, 5'd7, rnd));
      take_wb(wb);
      if (wb.data !== old) report_mismatch("mscratch_ops old", old, wb.data);
      read_csr(rv32_isa_pkg::MSCRATCH, rd_val);
      if (rd_val !== scratch_model) report_mismatch("mscratch_ops new", scratch_model, rd_val);
    end
    end_test("mscratch_ops", err_start);
  endtask

  task automatic write_suppression();
    int                  err_start;
    logic [31:0]         rnd;
    logic [31:0]         rd_val;
    ex_pipe_pkg::regwr_t wb;
    err_start = errors;
    drain();
    rnd = $random(seed);
    // rs1 value ignored when the source field is x0
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RS}, rv32_isa_pkg::MSCRATCH, 5'd0, 5'd2, rnd));
    take_wb(wb);
    if (wb.data !== scratch_model) report_mismatch("suppression rs", scratch_model, wb.data);
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RC}, rv32_isa_pkg::MSCRATCH, 5'd0, 5'd2, rnd));
    take_wb(wb);
    if (wb.data !== scratch_model) report_mismatch("suppression rc", scratch_model, wb.data);
    read_csr(rv32_isa_pkg::MSCRATCH, rd_val);
    if (rd_val !== scratch_model) report_mismatch("suppression keep", scratch_model, rd_val);
    rnd           = $random(seed);
    scratch_model = rnd;
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RW}, rv32_isa_pkg::MSCRATCH, 5'd9, 5'd0, rnd));
    idle(4);
    if (wb_q.size() != 0) begin
      $display("suppression: write-back pulse seen for an instruction with rd zero");
      errors++;
    end
    read_csr(rv32_isa_pkg::MSCRATCH, rd_val);
    if (rd_val !== scratch_model) report_mismatch("suppression rd0", scratch_model, rd_val);
    end_test("suppression", err_start);
  endtask

  task automatic mcycle_write_readback();
    int                  err_start;
    logic [31:0]         val;
    logic [31:0]         rd_val;
    ex_pipe_pkg::regwr_t wb;
    err_start = errors;
    drain();
    // upper bit clear so the low half cannot carry during the test
    val = $random(seed) & 32'h7fff_ffff;
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RW}, rv32_isa_pkg::MCYCLE, 5'd5, 5'd0, val));
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RS}, rv32_isa_pkg::MCYCLE, 5'd0, 5'd1, 32'd0));
    take_wb(wb);
    // the follower reads in the cycle right after the value lands
    if (wb.data !== val) report_mismatch("mcycle_write lo", val, wb.data);
    val = $random(seed);
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RW}, rv32_isa_pkg::MCYCLEH, 5'd5, 5'd0, val));
    read_csr(rv32_isa_pkg::MCYCLEH, rd_val);
    if (rd_val !== val) report_mismatch("mcycle_write hi", val, rd_val);
    end_test("mcycle_write", err_start);
  endtask

  task automatic minstret_retire_count();
    int                   err_start;
    int                   n;
    int                   k;
    logic [31:0]          rnd;
    logic [31:0]          r1;
    logic [31:0]          r2;
    ex_pipe_pkg::decode_t item;
    err_start = errors;
    drain();
    rnd = $random(seed);
    n   = 3 + int'(rnd[2:0]);
    read_csr(rv32_isa_pkg::MINSTRET, r1);
    for (k = 0; k < n; k++) begin
      item.ir               = $random(seed);
      item.ir.i_type.opcode = 7'b0110011;
      item.op1              = $random(seed);
      item.csr              = 1'b0;
      issue(item);
    end
    read_csr(rv32_isa_pkg::MINSTRET, r2);
    // the first read retires too
    if (r2 - r1 !== 32'(n + 1)) report_mismatch("minstret_count", 32'(n + 1), r2 - r1);
    end_test("minstret_count", err_start);
  endtask

  task automatic mcycle_rollover();
    int          err_start;
    logic [31:0] hi;
    logic [31:0] rd_val;
    err_start = errors;
    drain();
    hi = $random(seed) & 32'h7fff_ffff;
    // upper half first, so the carry lands on top of it
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RW}, rv32_isa_pkg::MCYCLEH, 5'd5, 5'd0, hi));
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RW}, rv32_isa_pkg::MCYCLE, 5'd5, 5'd0,
                     32'hffff_ffff));
    idle(3);
    read_csr(rv32_isa_pkg::MCYCLEH, rd_val);
    if (rd_val !== hi + 32'd1) report_mismatch("mcycle_rollover", hi + 32'd1, rd_val);
    end_test("mcycle_rollover", err_start);
  endtask

  task automatic write_backpressure();
    int                  err_start;
    logic [31:0]         val;
    logic [31:0]         old;
    ex_pipe_pkg::regwr_t wb;
    err_start = errors;
    drain();
    stall_cnt     = 0;
    val           = $random(seed);
    old           = scratch_model;
    scratch_model = val;
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RW}, rv32_isa_pkg::MSCRATCH, 5'd3, 5'd3, val));
    issue(encode_csr({1'b0, rv32_isa_pkg::CSR_RS}, rv32_isa_pkg::MSCRATCH, 5'd0, 5'd4, 32'd0));
    take_wb(wb);
    if (wb.sel !== 5'd3) report_mismatch("backpressure sel1", 32'd3, 32'(wb.sel));
    if (wb.data !== old) report_mismatch("backpressure data1", old, wb.data);
    take_wb(wb);
    if (wb.sel !== 5'd4) report_mismatch("backpressure sel2", 32'd4, 32'(wb.sel));
    if (wb.data !== val) report_mismatch("backpressure data2", val, wb.data);
    if (stall_cnt != 1) report_mismatch("backpressure stall", 32'd1, 32'(stall_cnt));
    end_test("backpressure", err_start);
  endtask

  initial begin
    seed          = 64;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    stall_cnt     = 0;
    scratch_model = 32'd0;
    rst_n         = 1'b0;
    decode        = '0;
    decode_vld    = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    mscratch_all_ops();
    write_suppression();
    mcycle_write_readback();
    minstret_retire_count();
    mcycle_rollover();
    write_backpressure();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/rv32_isa_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/csr_counter.sv
verilog/csr_operand_stage.sv
verilog/csr_access_stage.sv
verilog/ex_csr_top.sv
dv/ex_csr_assert.sv
dv/tb_ex_csr.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_ex_csr
FILELIST   := all.f
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failed
PASS_MSG   := Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
